/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = lsu_tb
FILELIST = sources.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '\*\* FAIL \*\*' $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* sources.f */
src/lsu_pkg.sv
src/ld_decode.sv
src/ld_select.sv
src/addr_stage.sv
src/mem_stage.sv
src/data_ram.sv
src/wb_stage.sv
src/lsu_top.sv
tests/lsu_sva.sv
tests/lsu_tb.sv

/* src/addr_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module addr_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  lsu_pkg::lsu_req_t          in_req,
    input  logic                       ms_allowin,
    output logic                       ms_valid_in,
    output lsu_pkg::ms_bus_t           ms_bus,
    output logic                       req_valid,
    output logic                       req_we,
    output logic [3:0]                 req_wstrb,
    output logic [lsu_pkg::ram_aw-1:0] req_index,
    output logic [31:0]                req_wdata
);

    logic              as_valid;
    lsu_pkg::lsu_req_t req_r;
    logic [31:0]       addr;
    logic              is_store;
    logic              misaligned;
    logic              ades;

    // one-cycle stage, ready-go is always true
    assign in_ready    = !as_valid || ms_allowin;
    assign ms_valid_in = as_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            as_valid <= 1'b0;
        end else if (in_ready) begin
            as_valid <= in_valid;
        end
        if (in_valid && in_ready) begin
            req_r <= in_req;
        end
    end

    // base plus sign-extended offset
    assign addr = req_r.base + {{16{req_r.offset[15]}}, req_r.offset};

    assign is_store = req_r.op inside {lsu_pkg::op_sb, lsu_pkg::op_sh, lsu_pkg::op_sw};

    always_comb begin
        case (req_r.op)
            lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh: misaligned = addr[0];
            lsu_pkg::op_lw, lsu_pkg::op_sw:                  misaligned = addr[1:0] != 2'b00;
            default:                                         misaligned = 1'b0;
        endcase
    end

    // load misalignment is reported by the mem stage, stores fault here
    assign ades = is_store && misaligned;

    always_comb begin
        ms_bus.op       = req_r.op;
        ms_bus.addr     = addr;
        ms_bus.dest     = req_r.dest;
        ms_bus.exc      = ades;
        ms_bus.exc_code = ades ? lsu_pkg::exc_ades : lsu_pkg::exc_none;
    end

    // store lanes, data replicated so the strobes pick the right bytes
    always_comb begin
        req_wstrb = 4'b0000;
        req_wdata = req_r.store_data;
        case (req_r.op)
            lsu_pkg::op_sb: begin
                req_wstrb = 4'b0001 << addr[1:0];
                req_wdata = {4{req_r.store_data[7:0]}};
            end
            lsu_pkg::op_sh: begin
                req_wstrb = 4'b0011 << {addr[1], 1'b0};
                req_wdata = {2{req_r.store_data[15:0]}};
            end
            lsu_pkg::op_sw: begin
                req_wstrb = 4'b1111;
            end
            default: begin
                req_wstrb = 4'b0000;
            end
        endcase
    end

    // request goes out on the edge the op enters the mem stage
    assign req_valid = as_valid && ms_allowin && !misaligned;
    assign req_we    = is_store;
    assign req_index = addr[lsu_pkg::ram_aw+1:2];

endmodule

`default_nettype wire

/* src/data_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module data_ram (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       req_valid,
    input  logic                       req_we,
    input  logic [3:0]                 req_wstrb,
    input  logic [lsu_pkg::ram_aw-1:0] req_index,
    input  logic [31:0]                req_wdata,
    input  logic                       resp_ack,
    output logic                       data_ok,
    output logic [31:0]                rdata
);

    logic [31:0] mem [lsu_pkg::ram_words];

    // storage, cleared in one reset cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < lsu_pkg::ram_words; i++) begin
                mem[i] <= 32'd0;
            end
        end else if (req_valid && req_we) begin
            for (int b = 0; b < 4; b++) begin
                if (req_wstrb[b]) begin
                    mem[req_index][8*b +: 8] <= req_wdata[8*b +: 8];
                end
            end
        end
    end

    // read data, old contents on a store
    always_ff @(posedge clk) begin
        if (req_valid) begin
            rdata <= mem[req_index];
        end
    end

    // response held until the mem stage takes it
    always_ff @(posedge clk) begin
        if (reset) begin
            data_ok <= 1'b0;
        end else if (req_valid) begin
            data_ok <= 1'b1;
        end else if (resp_ack) begin
            data_ok <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* src/ld_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module ld_decode (
    input  lsu_pkg::mem_op_e op,
    input  logic [1:0]       addr_low,
    output logic [3:0]       ld_rshift_op,
    output logic [3:0]       gr_we,
    output logic             adel
);

    logic [1:0] lwl_rot;

    // LWL rotates the word so byte addr_low lands in lane 3
    assign lwl_rot = addr_low + 2'd1;

    // ld_rshift_op is one-hot, bit n means rotate right by n bytes
    always_comb begin
        ld_rshift_op = 4'b0001;
        gr_we        = 4'b1111;
        adel         = 1'b0;
        case (op)
            lsu_pkg::op_lb, lsu_pkg::op_lbu: begin
                ld_rshift_op = 4'b0001 << addr_low;
            end
            lsu_pkg::op_lh, lsu_pkg::op_lhu: begin
                ld_rshift_op = 4'b0001 << addr_low;
                adel         = addr_low[0];
            end
            lsu_pkg::op_lw: begin
                adel = addr_low != 2'b00;
            end
            lsu_pkg::op_lwl: begin
                ld_rshift_op = 4'b0001 << lwl_rot;
                // upper lanes, more of them for higher offsets
                gr_we        = 4'b1111 << (2'd3 - addr_low);
            end
            lsu_pkg::op_lwr: begin
                ld_rshift_op = 4'b0001 << addr_low;
                gr_we        = 4'b1111 >> addr_low;
            end
            default: begin
                // stores write no register
                gr_we = 4'b0000;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/ld_select.sv */
`timescale 1ns/10ps
`default_nettype none

module ld_select (
    input  lsu_pkg::mem_op_e op,
    input  logic [3:0]       ld_rshift_op,
    input  logic [31:0]      rdata,
    output logic [31:0]      mem_result
);

    logic [31:0] rot;

    // byte rotate, covers plain shifts and the LWL/LWR placement
    always_comb begin
        case (ld_rshift_op)
            4'b0010: rot = {rdata[7:0], rdata[31:8]};
            4'b0100: rot = {rdata[15:0], rdata[31:16]};
            4'b1000: rot = {rdata[23:0], rdata[31:24]};
            default: rot = rdata;
        endcase
    end

    // extension for the narrow loads
    always_comb begin
        case (op)
            lsu_pkg::op_lb: begin
                mem_result = {{24{rot[7]}}, rot[7:0]};
            end
            lsu_pkg::op_lbu: begin
                mem_result = {24'd0, rot[7:0]};
            end
            lsu_pkg::op_lh: begin
                mem_result = {{16{rot[15]}}, rot[15:0]};
            end
            lsu_pkg::op_lhu: begin
                mem_result = {16'd0, rot[15:0]};
            end
            default: begin
                // LW, LWL, LWR, the byte enables select lanes later
                mem_result = rot;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // data RAM geometry, word addressed
    localparam int ram_words = 256;
    localparam int ram_aw    = $clog2(ram_words);

    // architectural register file
    localparam int nregs = 32;

    typedef enum logic [3:0] {
        op_lb  = 4'd0,
        op_lbu = 4'd1,
        op_lh  = 4'd2,
        op_lhu = 4'd3,
        op_lw  = 4'd4,
        op_lwl = 4'd5,
        op_lwr = 4'd6,
        op_sb  = 4'd7,
        op_sh  = 4'd8,
        op_sw  = 4'd9
    } mem_op_e;

    // MIPS cause codes, only the address errors are raised here
    typedef enum logic [4:0] {
        exc_none = 5'd0,
        exc_adel = 5'd4,
        exc_ades = 5'd5
    } exc_code_e;

    typedef struct packed {
        mem_op_e     op;
        logic [31:0] base;
        logic [15:0] offset;
        logic [31:0] store_data;
        logic [4:0]  dest;
    } lsu_req_t;

    // addr stage to mem stage
    typedef struct packed {
        mem_op_e     op;
        logic [31:0] addr;
        logic [4:0]  dest;
        logic        exc;
        exc_code_e   exc_code;
    } ms_bus_t;

    // mem stage to writeback, op rides along for the commit record
    typedef struct packed {
        mem_op_e     op;
        logic [4:0]  dest;
        logic [3:0]  gr_we;
        logic [31:0] result;
        logic        exc;
        exc_code_e   exc_code;
        logic [31:0] badvaddr;
    } ws_bus_t;

    typedef struct packed {
        mem_op_e     op;
        logic [4:0]  dest;
        logic [3:0]  gr_we;
        logic [31:0] reg_value;
        logic        exc;
        exc_code_e   exc_code;
        logic [31:0] badvaddr;
    } commit_t;

endpackage

`default_nettype wire

/* src/lsu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    output logic              in_ready,
    input  lsu_pkg::lsu_req_t in_req,
    output logic              commit_valid,
    input  logic              commit_ready,
    output lsu_pkg::commit_t  commit
);

    // stage handshakes
    logic             ms_allowin;
    logic             ms_valid_in;
    lsu_pkg::ms_bus_t ms_bus;
    logic             ws_allowin;
    logic             ws_valid_in;
    lsu_pkg::ws_bus_t ws_bus;

    // data RAM port
    logic                       req_valid;
    logic                       req_we;
    logic [3:0]                 req_wstrb;
    logic [lsu_pkg::ram_aw-1:0] req_index;
    logic [31:0]                req_wdata;
    logic                       resp_ack;
    logic                       data_ok;
    logic [31:0]                rdata;

    addr_stage u_addr_stage (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_req      (in_req),
        .ms_allowin  (ms_allowin),
        .ms_valid_in (ms_valid_in),
        .ms_bus      (ms_bus),
        .req_valid   (req_valid),
        .req_we      (req_we),
        .req_wstrb   (req_wstrb),
        .req_index   (req_index),
        .req_wdata   (req_wdata)
    );

    mem_stage u_mem_stage (
        .clk         (clk),
        .reset       (reset),
        .ms_valid_in (ms_valid_in),
        .ms_allowin  (ms_allowin),
        .ms_bus      (ms_bus),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .resp_ack    (resp_ack),
        .ws_allowin  (ws_allowin),
        .ws_valid_in (ws_valid_in),
        .ws_bus      (ws_bus)
    );

    data_ram u_data_ram (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_we    (req_we),
        .req_wstrb (req_wstrb),
        .req_index (req_index),
        .req_wdata (req_wdata),
        .resp_ack  (resp_ack),
        .data_ok   (data_ok),
        .rdata     (rdata)
    );

    wb_stage u_wb_stage (
        .clk          (clk),
        .reset        (reset),
        .ws_valid_in  (ws_valid_in),
        .ws_allowin   (ws_allowin),
        .ws_bus       (ws_bus),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit       (commit)
    );

endmodule

`default_nettype wire

/* src/mem_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_stage (
    input  logic             clk,
    input  logic             reset,
    input  logic             ms_valid_in,
    output logic             ms_allowin,
    input  lsu_pkg::ms_bus_t ms_bus,
    input  logic             data_ok,
    input  logic [31:0]      rdata,
    output logic             resp_ack,
    input  logic             ws_allowin,
    output logic             ws_valid_in,
    output lsu_pkg::ws_bus_t ws_bus
);

    logic             ms_valid;
    lsu_pkg::ms_bus_t ms_bus_r;
    logic             ms_ready_go;
    logic [3:0]       ld_rshift_op;
    logic [3:0]       dec_gr_we;
    logic             adel;
    logic             ms_fault;
    logic [31:0]      mem_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= ms_valid_in;
        end
        if (ms_valid_in && ms_allowin) begin
            ms_bus_r <= ms_bus;
        end
    end

    ld_decode u_ld_decode (
        .op           (ms_bus_r.op),
        .addr_low     (ms_bus_r.addr[1:0]),
        .ld_rshift_op (ld_rshift_op),
        .gr_we        (dec_gr_we),
        .adel         (adel)
    );

    ld_select u_ld_select (
        .op           (ms_bus_r.op),
        .ld_rshift_op (ld_rshift_op),
        .rdata        (rdata),
        .mem_result   (mem_result)
    );

    // a faulted op never reached the RAM, so it does not wait
    assign ms_fault    = ms_bus_r.exc || adel;
    assign ms_ready_go = ms_fault || data_ok;
    assign ms_allowin  = !ms_valid || (ms_ready_go && ws_allowin);
    assign ws_valid_in = ms_valid && ms_ready_go;

    // releases the held RAM response
    assign resp_ack = ms_valid && !ms_fault && data_ok && ws_allowin;

    always_comb begin
        ws_bus.op     = ms_bus_r.op;
        ws_bus.dest   = ms_bus_r.dest;
        ws_bus.gr_we  = ms_fault ? 4'b0000 : dec_gr_we;
        ws_bus.result = mem_result;
        ws_bus.exc    = ms_fault;
        // store fault from the addr stage wins
        if (ms_bus_r.exc) begin
            ws_bus.exc_code = ms_bus_r.exc_code;
        end else if (adel) begin
            ws_bus.exc_code = lsu_pkg::exc_adel;
        end else begin
            ws_bus.exc_code = lsu_pkg::exc_none;
        end
        ws_bus.badvaddr = ms_bus_r.addr;
    end

endmodule

`default_nettype wire

/* src/wb_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_stage (
    input  logic             clk,
    input  logic             reset,
    input  logic             ws_valid_in,
    output logic             ws_allowin,
    input  lsu_pkg::ws_bus_t ws_bus,
    output logic             commit_valid,
    input  logic             commit_ready,
    output lsu_pkg::commit_t commit
);

    logic [31:0] regs [lsu_pkg::nregs];
    logic [31:0] old_value;
    logic [31:0] merged;
    logic        accept;

    assign ws_allowin = !commit_valid || commit_ready;
    assign accept     = ws_valid_in && ws_allowin;

    // byte-enable merge into the current register value
    assign old_value = regs[ws_bus.dest];

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = ws_bus.gr_we[b] ? ws_bus.result[8*b +: 8] : old_value[8*b +: 8];
        end
    end

    // r0 is never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < lsu_pkg::nregs; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (accept && ws_bus.dest != 5'd0) begin
            regs[ws_bus.dest] <= merged;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
        end else if (ws_allowin) begin
            commit_valid <= ws_valid_in;
        end
        if (accept) begin
            commit.op        <= ws_bus.op;
            commit.dest      <= ws_bus.dest;
            commit.gr_we     <= ws_bus.gr_we;
            commit.reg_value <= (ws_bus.dest == 5'd0) ? 32'd0 : merged;
            commit.exc       <= ws_bus.exc;
            commit.exc_code  <= ws_bus.exc_code;
            commit.badvaddr  <= ws_bus.badvaddr;
        end
    end

endmodule

`default_nettype wire

/* tests/lsu_stim.txt */
# op base offset store_data dest, then expected gr_we reg_value exc_code badvaddr
# op codes 0 lb, 1 lbu, 2 lh, 3 lhu, 4 lw, 5 lwl, 6 lwr, 7 sb, 8 sh, 9 sw
9 00000100 0000 8badf00d 00 0 00000000 00 00000100 # sw
4 00000100 0000 00000000 01 f 8badf00d 00 00000100 # lw
9 000000f0 0014 12345678 00 0 00000000 00 00000104 # sw
4 00000200 ff04 00000000 02 f 12345678 00 00000104 # lw, negative offset
8 00000108 0000 0000a5c3 00 0 00000000 00 00000108 # sh low half
8 00000108 0002 ffff7e01 00 0 00000000 00 0000010a # sh high half
2 00000108 0000 00000000 03 f ffffa5c3 00 00000108 # lh
3 00000108 0000 00000000 04 f 0000a5c3 00 00000108 # lhu
2 00000108 0002 00000000 05 f 00007e01 00 0000010a # lh
3 0000010a 0000 00000000 06 f 00007e01 00 0000010a # lhu
7 0000010c 0000 00000080 00 0 00000000 00 0000010c # sb
7 0000010c 0001 0000007f 00 0 00000000 00 0000010d # sb
7 0000010c 0003 aabbccfe 00 0 00000000 00 0000010f # sb
0 0000010c 0000 00000000 07 f ffffff80 00 0000010c # lb
1 0000010c 0000 00000000 08 f 00000080 00 0000010c # lbu
0 0000010c 0001 00000000 09 f 0000007f 00 0000010d # lb
0 0000010c 0003 00000000 0a f fffffffe 00 0000010f # lb
1 0000010c 0002 00000000 0b f 00000000 00 0000010e # lbu
5 00000104 0000 00000000 01 8 78adf00d 00 00000104 # lwl
6 00000101 0000 00000000 01 7 788badf0 00 00000101 # lwr
5 00000100 0006 00000000 02 e 34567878 00 00000106 # lwl
6 00000100 0003 00000000 02 1 3456788b 00 00000103 # lwr
4 00000100 0002 00000000 03 0 ffffa5c3 04 00000102 # lw misaligned
2 00000107 0000 00000000 04 0 0000a5c3 04 00000107 # lh misaligned
3 00000200 fef1 00000000 05 0 00007e01 04 000000f1 # lhu misaligned
5 00000108 0000 00000000 03 8 c3ffa5c3 00 00000108 # lwl keeps r3 low bytes
9 0000010c 0002 deadbeef 00 0 00000000 05 0000010e # sw misaligned
8 0000010d 0000 00001111 00 0 00000000 05 0000010d # sh misaligned
4 0000010c 0000 00000000 0d f fe007f80 00 0000010c # lw, memory unchanged
4 00000100 0000 00000000 00 f 00000000 00 00000100 # lw into r0
0 0000010c 0000 00000000 00 f 00000000 00 0000010c # lb into r0
7 000003fc 0003 000000a7 00 0 00000000 00 000003ff # sb top word
4 000003fc 0000 00000000 1f f a7000000 00 000003fc # lw
0 00000400 ffff 00000000 1e f ffffffa7 00 000003ff # lb

/* tests/lsu_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_sva (
    input logic             clk,
    input logic             reset,
    input logic             commit_valid,
    input logic             commit_ready,
    input lsu_pkg::commit_t commit,
    input logic             req_valid,
    input logic             ws_valid_in,
    input lsu_pkg::ws_bus_t ws_bus,
    input logic             data_ok
);

    // a stalled commit keeps its record
    property commit_held_p;
        @(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit);
    endproperty

    property reset_idle_p;
        @(posedge clk) reset |=> !commit_valid && !req_valid;
    endproperty

    // a response only exists while a clean op waits in the mem stage
    property data_ok_owned_p;
        @(posedge clk) disable iff (reset)
        data_ok |-> ws_valid_in && !ws_bus.exc;
    endproperty

    a_commit_held: assert property (commit_held_p)
        else $error("commit record changed while stalled");

    a_reset_idle: assert property (reset_idle_p)
        else $error("commit_valid or req_valid high after reset");

    a_data_ok_owned: assert property (data_ok_owned_p)
        else $error("data_ok high with no outstanding request");

endmodule

bind lsu_top lsu_sva u_lsu_sva (
    .clk          (clk),
    .reset        (reset),
    .commit_valid (commit_valid),
    .commit_ready (commit_ready),
    .commit       (commit),
    .req_valid    (req_valid),
    .ws_valid_in  (ws_valid_in),
    .ws_bus       (ws_bus),
    .data_ok      (data_ok)
);

`default_nettype wire

/* tests/lsu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_tb;

    // one stim line, the request and the commit it must produce
    typedef struct packed {
        lsu_pkg::lsu_req_t req;
        logic [3:0]        gr_we;
        logic [31:0]       reg_value;
        logic [4:0]        exc_code;
        logic [31:0]       badvaddr;
    } vec_t;

    logic              clk;
    logic              reset;
    logic              in_valid;
    logic              in_ready;
    lsu_pkg::lsu_req_t in_req;
    logic              commit_valid;
    logic              commit_ready;
    lsu_pkg::commit_t  commit;

    vec_t   vecs[$];
    integer seed;
    int     errors;
    int     checked;
    int     cycles;
    int     limit;

    lsu_top u_lsu_top (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_req       (in_req),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit       (commit)
    );

    always #10 clk = ~clk;

    task automatic finish_run();
        $display("errors: %0d, commits checked: %0d of %0d", errors, checked, vecs.size());
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic load_vectors();
        int               fd;
        int               n;
        logic [8*160-1:0] line;
        logic [31:0]      f [9];
        vec_t             v;
        fd = $fopen("tests/lsu_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/lsu_stim.txt for reading");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                // comment lines yield no fields
                if (n == 9) begin
                    v.req.op         = lsu_pkg::mem_op_e'(f[0][3:0]);
                    v.req.base       = f[1];
                    v.req.offset     = f[2][15:0];
                    v.req.store_data = f[3];
                    v.req.dest       = f[4][4:0];
                    v.gr_we          = f[5][3:0];
                    v.reg_value      = f[6];
                    v.exc_code       = f[7][4:0];
                    v.badvaddr       = f[8];
                    vecs.push_back(v);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic report_mismatch(input string field, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERR %0t: commit %0d %s got %h expected %h", $time, checked, field, got, exp);
        errors++;
    endtask

    task automatic check_commit(input lsu_pkg::commit_t got, input vec_t exp);
        if (got.op != exp.req.op) begin
            report_mismatch("op", 32'(got.op), 32'(exp.req.op));
        end
        if (got.dest != exp.req.dest) begin
            report_mismatch("dest", 32'(got.dest), 32'(exp.req.dest));
        end
        if (got.gr_we != exp.gr_we) begin
            report_mismatch("gr_we", 32'(got.gr_we), 32'(exp.gr_we));
        end
        if (got.reg_value != exp.reg_value) begin
            report_mismatch("reg_value", got.reg_value, exp.reg_value);
        end
        if (got.exc != (exp.exc_code != 5'd0)) begin
            report_mismatch("exc", 32'(got.exc), 32'(exp.exc_code != 5'd0));
        end
        if (got.exc_code != exp.exc_code) begin
            report_mismatch("exc_code", 32'(got.exc_code), 32'(exp.exc_code));
        end
        if (got.badvaddr != exp.badvaddr) begin
            report_mismatch("badvaddr", got.badvaddr, exp.badvaddr);
        end
    endtask

    // hold one request until the DUT takes it
    task automatic drive_op(input lsu_pkg::lsu_req_t req);
        logic taken;
        in_valid = 1'b1;
        in_req   = req;
        taken    = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
        end
        #2;
    endtask

    // commit_ready low about one cycle in four
    always @(posedge clk) begin
        #2;
        commit_ready = (($random(seed) & 32'h3) != 32'h0);
    end

    // transfers are decided at the next edge, values are settled here
    always @(negedge clk) begin
        if (!reset && commit_valid && commit_ready) begin
            if (checked < vecs.size()) begin
                check_commit(commit, vecs[checked]);
            end else begin
                $display("an extra commit appeared at %0t after all operations", $time);
                errors++;
            end
            checked++;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, only %0d of %0d operations committed",
                     cycles, checked, vecs.size());
            errors++;
            finish_run();
        end
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_req       = '0;
        commit_ready = 1'b0;
        seed         = 32'h86d8;
        errors       = 0;
        checked      = 0;
        cycles       = 0;
        load_vectors();
        if (vecs.size() == 0) begin
            $display("no operations were read from the stim file");
            errors++;
        end
        limit = 20 * vecs.size() + 100;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        foreach (vecs[i]) begin
            drive_op(vecs[i].req);
        end
        in_valid = 1'b0;
        while (checked < vecs.size()) begin
            @(posedge clk);
        end
        // idle a little so stray commits get caught
        repeat (5) @(posedge clk);
        finish_run();
    end

endmodule

`default_nettype wire
